// ==== verilog/sram_params.svh ====
`ifndef SRAM_PARAMS_SVH
`define SRAM_PARAMS_SVH

// bank organisation.
`define SRAM_NUM_BANKS 4
`define SRAM_BANK_DEPTH 128
`define SRAM_ADDR_W 7

// a stored line and the half returned per bank on a read.
`define SRAM_LINE_W 64
`define SRAM_HALF_W 32

// response slots, also the request credits in circulation.
`define SRAM_RSP_DEPTH 4

// wide enough to hold SRAM_RSP_DEPTH.
`define SRAM_CREDIT_W 3

`endif

// ==== verilog/sram_pkg.sv ====
`default_nettype none

`include "sram_params.svh"

package sram_pkg;

	typedef logic [`SRAM_ADDR_W-1:0] bank_addr_t;

	// bank 0 address sits in the low field.
	typedef logic [`SRAM_NUM_BANKS*`SRAM_ADDR_W-1:0] word_line_t;

	typedef logic [`SRAM_LINE_W-1:0] line_t;

	typedef logic [`SRAM_HALF_W-1:0] half_t;

	// one bit per bank.
	typedef logic [`SRAM_NUM_BANKS-1:0] bank_mask_t;

	// four returned halves, bank 0 lowest.
	typedef struct packed {
		half_t half3;
		half_t half2;
		half_t half1;
		half_t half0;
	} rsp_t;

	typedef logic [`SRAM_CREDIT_W-1:0] credit_t;

endpackage : sram_pkg

`default_nettype wire

// ==== verilog/sram_req_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "sram_params.svh"

module sram_req_ctrl
	import sram_pkg::*;
(
	input  logic       clk_1,
	input  logic       clk_2,
	input  logic       req_valid,
	input  logic       rw_sel,
	input  word_line_t wl,
	input  line_t      bl,
	input  bank_mask_t cs,
	input  bank_mask_t dsel,
	input  logic       rsp_pop,
	output logic       req_credit,
	output bank_mask_t bank_wr,
	output logic       bank_rd,
	output word_line_t bank_addr,
	output bank_mask_t bank_dsel,
	output logic       rsp_push
);

	logic    precharged;
	logic    wr_req;
	logic    rd_drop;
	credit_t owed;
	credit_t owed_next;
	credit_t held;

	// a read is only valid with all bit lines precharged high.
	assign precharged = (bl == '1);
	assign wr_req = req_valid && rw_sel;
	assign rd_drop = req_valid && !rw_sel && !precharged;

	// lowest set chip select takes the write.
	assign bank_wr = wr_req ? (cs & (~cs + bank_mask_t'(1))) : '0;
	assign bank_rd = req_valid && !rw_sel && precharged;
	assign bank_addr = wl;
	assign bank_dsel = dsel;

	// writes and dropped reads return their credit here, issued reads on pop.
	always_comb begin
		owed_next = owed;
		if (wr_req || rd_drop) begin
			owed_next = owed_next + credit_t'(1);
		end
		if (rsp_pop) begin
			owed_next = owed_next + credit_t'(1);
		end
		if (owed != '0) begin
			owed_next = owed_next - credit_t'(1);
		end
	end

	always_ff @(posedge clk_1 or posedge clk_2) begin
		if (clk_2) begin
			owed <= credit_t'(`SRAM_RSP_DEPTH);
			req_credit <= 1'b0;
			rsp_push <= 1'b0;
			held <= '0;
		end else begin
			owed <= owed_next;
			// one credit per cycle while any are owed.
			req_credit <= (owed != '0);
			// bank data is registered, so the push trails the issue by a cycle.
			rsp_push <= bank_rd;
			held <= held + credit_t'(req_credit) - credit_t'(req_valid);
		end
	end

	// the requester spends only credits granted earlier.
	a_req_has_credit: assert property (
		@(posedge clk_1) disable iff (clk_2)
		req_valid |-> (held != '0)
	);

	a_wr_onehot: assert property (
		@(posedge clk_1) disable iff (clk_2)
		$onehot0(bank_wr)
	);

endmodule : sram_req_ctrl

`default_nettype wire

// ==== verilog/sram_bank.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "sram_params.svh"

module sram_bank
	import sram_pkg::*;
(
	input  logic       clk_1,
	input  logic       clk_2,
	input  logic       wr,
	input  logic       rd,
	input  bank_addr_t addr,
	input  logic       dsel,
	input  line_t      wdata,
	output half_t      rdata
);

	line_t mem [`SRAM_BANK_DEPTH];
	line_t rd_line;

	always_ff @(posedge clk_1) begin
		if (wr) begin
			mem[addr] <= wdata;
		end
	end

	assign rd_line = mem[addr];

	// dsel picks the upper half, zero when idle.
	always_ff @(posedge clk_1 or posedge clk_2) begin
		if (clk_2) begin
			rdata <= '0;
		end else if (rd) begin
			rdata <= dsel ? rd_line[`SRAM_LINE_W-1:`SRAM_HALF_W] : rd_line[`SRAM_HALF_W-1:0];
		end else begin
			rdata <= '0;
		end
	end

	// controller issues a request as either a write or a read, never both.
	a_no_wr_rd: assert property (
		@(posedge clk_1) disable iff (clk_2)
		!(wr && rd)
	);

endmodule : sram_bank

`default_nettype wire

// ==== verilog/sram_rsp_queue.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "sram_params.svh"

module sram_rsp_queue
	import sram_pkg::*;
(
	input  logic clk_1,
	input  logic clk_2,
	input  logic push,
	input  rsp_t push_data,
	input  logic rsp_credit,
	output logic rsp_valid,
	output rsp_t rsp_data,
	output logic pop
);

	localparam int PTR_W = $clog2(`SRAM_RSP_DEPTH);
	localparam logic [PTR_W:0] FULL = `SRAM_RSP_DEPTH;

	rsp_t             entries [`SRAM_RSP_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0]   count;
	credit_t          credits;

	// a response goes out only with an entry and a consumer credit.
	assign rsp_valid = (count != '0) && (credits != '0);
	assign pop = rsp_valid;
	assign rsp_data = entries[rd_ptr];

	always_ff @(posedge clk_1) begin
		if (push) begin
			entries[wr_ptr] <= push_data;
		end
	end

	always_ff @(posedge clk_1 or posedge clk_2) begin
		if (clk_2) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			credits <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
			credits <= credits + credit_t'(rsp_credit) - credit_t'(pop);
		end
	end

	// request credits bound the reads in flight to the queue size.
	a_no_push_full: assert property (
		@(posedge clk_1) disable iff (clk_2)
		push |-> (count != FULL)
	);

	a_credit_no_wrap: assert property (
		@(posedge clk_1) disable iff (clk_2)
		(rsp_credit && !pop) |-> (credits != '1)
	);

endmodule : sram_rsp_queue

`default_nettype wire

// ==== verilog/sram_array_top.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "sram_params.svh"

module sram_array_top
	import sram_pkg::*;
(
	input  logic       clk_1,
	input  logic       clk_2,
	input  logic       req_valid,
	input  logic       rw_sel,
	input  word_line_t wl,
	input  line_t      bl,
	input  bank_mask_t cs,
	input  bank_mask_t dsel,
	input  logic       rsp_credit,
	output logic       req_credit,
	output logic       rsp_valid,
	output rsp_t       rsp_data
);

	bank_mask_t                  bank_wr;
	logic                        bank_rd;
	word_line_t                  bank_addr;
	bank_mask_t                  bank_dsel;
	logic                        rsp_push;
	logic                        rsp_pop;
	half_t [`SRAM_NUM_BANKS-1:0] bank_rdata;

	sram_req_ctrl u_req_ctrl (
		.clk_1      (clk_1),
		.clk_2      (clk_2),
		.req_valid  (req_valid),
		.rw_sel     (rw_sel),
		.wl         (wl),
		.bl         (bl),
		.cs         (cs),
		.dsel       (dsel),
		.rsp_pop    (rsp_pop),
		.req_credit (req_credit),
		.bank_wr    (bank_wr),
		.bank_rd    (bank_rd),
		.bank_addr  (bank_addr),
		.bank_dsel  (bank_dsel),
		.rsp_push   (rsp_push)
	);

	// each bank takes its own field of the word line.
	for (genvar b = 0; b < `SRAM_NUM_BANKS; b++) begin : g_bank
		sram_bank u_bank (
			.clk_1 (clk_1),
			.clk_2 (clk_2),
			.wr    (bank_wr[b]),
			.rd    (bank_rd),
			.addr  (bank_addr[b*`SRAM_ADDR_W +: `SRAM_ADDR_W]),
			.dsel  (bank_dsel[b]),
			.wdata (bl),
			.rdata (bank_rdata[b])
		);
	end

	// bank 0 half lands in the low field of the response.
	sram_rsp_queue u_rsp_queue (
		.clk_1      (clk_1),
		.clk_2      (clk_2),
		.push       (rsp_push),
		.push_data  (bank_rdata),
		.rsp_credit (rsp_credit),
		.rsp_valid  (rsp_valid),
		.rsp_data   (rsp_data),
		.pop        (rsp_pop)
	);

endmodule : sram_array_top

`default_nettype wire

// ==== verif/sram_array_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "sram_params.svh"

module sram_array_tb
	import sram_pkg::*;
();

	localparam int OP_WR = 0;
	localparam int OP_RD = 1;

	typedef struct {
		int         test;
		int         op;
		word_line_t wl;
		line_t      bl;
		bank_mask_t cs;
		bank_mask_t dsel;
		bit         exp_rsp;
		bit         hold;
	} row_t;

	logic       clk_1;
	logic       clk_2;
	logic       req_valid;
	logic       rw_sel;
	word_line_t wl;
	line_t      bl;
	bank_mask_t cs;
	bank_mask_t dsel;
	logic       rsp_credit;
	logic       req_credit;
	logic       rsp_valid;
	rsp_t       rsp_data;

	row_t        rows[$];
	rsp_t        exp_q[$];
	line_t       model_mem [`SRAM_NUM_BANKS][`SRAM_BANK_DEPTH];
	logic [15:0] lfsr_state;
	int          credits;
	int          outstanding;
	int          accepted_held;
	int          errors;
	int          checks;
	int          tests_run;
	int          tests_failed;
	int          err_base;
	int          cur_test;
	bit          consumer_en;
	bit          grant_next;
	bit          rsp_while_held;
	bit          hold_used;
	bit          table_ready;

	sram_array_top DUT (
		.clk_1      (clk_1),
		.clk_2      (clk_2),
		.req_valid  (req_valid),
		.rw_sel     (rw_sel),
		.wl         (wl),
		.bl         (bl),
		.cs         (cs),
		.dsel       (dsel),
		.rsp_credit (rsp_credit),
		.req_credit (req_credit),
		.rsp_valid  (rsp_valid),
		.rsp_data   (rsp_data)
	);

	always #20 clk_1 = ~clk_1;

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 16'hB400;
		end
		return s >> 1;
	endfunction

	// one lfsr step per data bit.
	task automatic next_line(output line_t v);
		for (int i = 0; i < `SRAM_LINE_W; i++) begin
			v[i] = lfsr_state[0];
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	function automatic word_line_t pack_wl(input bank_addr_t a0, input bank_addr_t a1,
			input bank_addr_t a2, input bank_addr_t a3);
		return {a3, a2, a1, a0};
	endfunction

	function automatic string test_name(input int t);
		case (t)
			1: return "reset credits";
			2: return "write and read back";
			3: return "write priority";
			4: return "read without precharge";
			default: return "back-pressure";
		endcase
	endfunction

	// the lowest selected bank takes the write.
	task automatic model_write(input word_line_t a, input bank_mask_t sel, input line_t data);
		bit done;
		done = 1'b0;
		for (int b = 0; b < `SRAM_NUM_BANKS; b++) begin
			if (sel[b] && !done) begin
				model_mem[b][a[b*`SRAM_ADDR_W +: `SRAM_ADDR_W]] = data;
				done = 1'b1;
			end
		end
	endtask

	function automatic rsp_t model_read(input word_line_t a, input bank_mask_t sel);
		logic [`SRAM_NUM_BANKS*`SRAM_HALF_W-1:0] flat;
		line_t line;
		for (int b = 0; b < `SRAM_NUM_BANKS; b++) begin
			line = model_mem[b][a[b*`SRAM_ADDR_W +: `SRAM_ADDR_W]];
			flat[b*`SRAM_HALF_W +: `SRAM_HALF_W] =
				sel[b] ? line[`SRAM_LINE_W-1:`SRAM_HALF_W] : line[`SRAM_HALF_W-1:0];
		end
		return rsp_t'(flat);
	endfunction

	task automatic add_row(input int test, input int op, input word_line_t a, input line_t data,
			input bank_mask_t sel, input bank_mask_t half, input bit exp_rsp, input bit hold);
		row_t r;
		r.test = test;
		r.op = op;
		r.wl = a;
		r.bl = data;
		r.cs = sel;
		r.dsel = half;
		r.exp_rsp = exp_rsp;
		r.hold = hold;
		rows.push_back(r);
	endtask

	task automatic build_table();
		word_line_t spread;
		word_line_t same;
		spread = pack_wl(7'd5, 7'd17, 7'd99, 7'd127);
		same = pack_wl(7'd40, 7'd40, 7'd40, 7'd40);
		add_row(2, OP_WR, pack_wl(7'd5, 7'd0, 7'd0, 7'd0), '0, 4'b0001, 4'b0000, 1'b0, 1'b0);
		add_row(2, OP_WR, pack_wl(7'd0, 7'd17, 7'd0, 7'd0), '0, 4'b0010, 4'b0000, 1'b0, 1'b0);
		add_row(2, OP_WR, pack_wl(7'd0, 7'd0, 7'd99, 7'd0), '0, 4'b0100, 4'b0000, 1'b0, 1'b0);
		add_row(2, OP_WR, pack_wl(7'd0, 7'd0, 7'd0, 7'd127), '0, 4'b1000, 4'b0000, 1'b0, 1'b0);
		add_row(2, OP_RD, spread, '1, 4'b0000, 4'b0101, 1'b1, 1'b0);
		add_row(2, OP_RD, spread, '1, 4'b0000, 4'b1010, 1'b1, 1'b0);
		add_row(2, OP_RD, spread, '1, 4'b0000, 4'b0000, 1'b1, 1'b0);
		add_row(2, OP_RD, spread, '1, 4'b0000, 4'b1111, 1'b1, 1'b0);
		add_row(3, OP_WR, same, '0, 4'b0001, 4'b0000, 1'b0, 1'b0);
		add_row(3, OP_WR, same, '0, 4'b0010, 4'b0000, 1'b0, 1'b0);
		add_row(3, OP_WR, same, '0, 4'b0100, 4'b0000, 1'b0, 1'b0);
		add_row(3, OP_WR, same, '0, 4'b1000, 4'b0000, 1'b0, 1'b0);
		add_row(3, OP_WR, same, '0, 4'b0110, 4'b0000, 1'b0, 1'b0);
		add_row(3, OP_WR, same, '0, 4'b1100, 4'b0000, 1'b0, 1'b0);
		add_row(3, OP_WR, same, '0, 4'b0000, 4'b0000, 1'b0, 1'b0);
		add_row(3, OP_RD, same, '1, 4'b0000, 4'b0000, 1'b1, 1'b0);
		add_row(3, OP_RD, same, '1, 4'b0000, 4'b1111, 1'b1, 1'b0);
		add_row(4, OP_RD, spread, 64'h0, 4'b0000, 4'b0011, 1'b0, 1'b0);
		add_row(4, OP_RD, spread, 64'hFFFF_FFFF_FFFF_FFFE, 4'b0000, 4'b1100, 1'b0, 1'b0);
		add_row(4, OP_RD, spread, 64'h7FFF_FFFF_FFFF_FFFF, 4'b0000, 4'b1001, 1'b0, 1'b0);
		add_row(4, OP_RD, spread, '1, 4'b0000, 4'b0110, 1'b1, 1'b0);
		for (int i = 0; i < 6; i++) begin
			add_row(5, OP_RD, (i % 2 == 0) ? spread : same, '1, 4'b0000,
				bank_mask_t'(i * 5), 1'b1, 1'b1);
		end
	endtask

	task automatic report_test(input int t);
		int n;
		n = errors - err_base;
		tests_run++;
		if (n == 0) begin
			$display("test %0d %s: ok", t, test_name(t));
		end else begin
			tests_failed++;
			$display("test %0d %s: %0d errors", t, test_name(t), n);
		end
	endtask

	task automatic release_consumer();
		checks += 2;
		assert (!rsp_while_held) else begin
			$display("ERROR: rsp_valid went high while consumer credits were withheld");
			errors++;
		end
		assert (accepted_held <= `SRAM_RSP_DEPTH) else begin
			$display("FAIL accepted requests got %h expected at most %h",
				accepted_held, `SRAM_RSP_DEPTH);
			errors++;
		end
		consumer_en = 1'b1;
	endtask

	task automatic wait_credit();
		int stall;
		stall = 0;
		while (credits == 0) begin
			@(posedge clk_1);
			#1;
			stall++;
			// the requester has stalled, so open the response side.
			if (!consumer_en && stall == 16) begin
				release_consumer();
			end
		end
	endtask

	task automatic apply_row(input row_t r);
		line_t data;
		wait_credit();
		data = r.bl;
		if (r.op == OP_WR) begin
			next_line(data);
		end
		req_valid = 1'b1;
		rw_sel = (r.op == OP_WR);
		wl = r.wl;
		bl = data;
		cs = r.cs;
		dsel = r.dsel;
		credits--;
		if (!consumer_en) begin
			accepted_held++;
		end
		if (r.op == OP_WR) begin
			model_write(r.wl, r.cs, data);
		end else if (r.exp_rsp) begin
			exp_q.push_back(model_read(r.wl, r.dsel));
		end
		@(posedge clk_1);
		#1;
		req_valid = 1'b0;
	endtask

	// wait for all responses and all request credits to come back.
	task automatic end_test(input int t);
		int waited;
		waited = 0;
		if (!consumer_en) begin
			release_consumer();
		end
		while ((exp_q.size() != 0 || credits != `SRAM_RSP_DEPTH) && waited < 60) begin
			@(posedge clk_1);
			#1;
			waited++;
		end
		checks += 2;
		assert (exp_q.size() == 0) else begin
			$display("ERROR: %0d expected responses never arrived", exp_q.size());
			errors++;
		end
		assert (credits == `SRAM_RSP_DEPTH) else begin
			$display("FAIL req_credit count got %h expected %h", credits, `SRAM_RSP_DEPTH);
			errors++;
		end
		report_test(t);
	endtask

	always @(negedge clk_1) begin : monitor
		rsp_t expected;
		if (req_credit) begin
			credits++;
		end
		if (rsp_valid) begin
			if (!consumer_en) begin
				rsp_while_held = 1'b1;
			end
			checks++;
			assert (exp_q.size() != 0) else begin
				$display("ERROR: response arrived with no read outstanding");
				errors++;
			end
			if (exp_q.size() != 0) begin
				expected = exp_q.pop_front();
				outstanding--;
				checks++;
				assert (rsp_data === expected) else begin
					$display("FAIL rsp_data got %h expected %h", rsp_data, expected);
					errors++;
				end
			end
		end
		// the consumer grants a slot only for a response still to come.
		grant_next = consumer_en && (exp_q.size() > outstanding);
		if (grant_next) begin
			outstanding++;
		end
	end

	always @(posedge clk_1) begin
		#1;
		rsp_credit = grant_next;
	end

	initial begin : watchdog
		int limit;
		wait (table_ready);
		limit = (rows.size() + 1) * 40 + 200;
		repeat (limit) @(posedge clk_1);
		$display("ERROR: watchdog expired after %0d cycles", limit);
		$display("TESTBENCH FAILED");
		$finish;
	end

	initial begin
		clk_1 = 1'b0;
		clk_2 = 1'b1;
		req_valid = 1'b0;
		rw_sel = 1'b0;
		wl = '0;
		bl = '0;
		cs = '0;
		dsel = '0;
		rsp_credit = 1'b0;
		lfsr_state = 16'd68;
		// the monitor flags any rsp_valid until the first request.
		consumer_en = 1'b0;
		rsp_while_held = 1'b0;
		build_table();
		table_ready = 1'b1;

		repeat (4) @(posedge clk_1);
		#1;
		clk_2 = 1'b0;

		err_base = errors;
		repeat (10) begin
			@(posedge clk_1);
			#1;
		end
		checks += 2;
		assert (credits == `SRAM_RSP_DEPTH) else begin
			$display("FAIL req_credit count got %h expected %h", credits, `SRAM_RSP_DEPTH);
			errors++;
		end
		assert (!rsp_while_held) else begin
			$display("ERROR: rsp_valid went high before any request was sent");
			errors++;
		end
		report_test(1);
		consumer_en = 1'b1;

		cur_test = rows[0].test;
		err_base = errors;
		hold_used = 1'b0;
		for (int i = 0; i < rows.size(); i++) begin
			if (rows[i].test != cur_test) begin
				end_test(cur_test);
				cur_test = rows[i].test;
				err_base = errors;
				hold_used = 1'b0;
			end
			if (rows[i].hold && !hold_used) begin
				consumer_en = 1'b0;
				accepted_held = 0;
				rsp_while_held = 1'b0;
				hold_used = 1'b1;
			end
			apply_row(rows[i]);
		end
		end_test(cur_test);

		$display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
			tests_run, tests_failed, checks, errors);
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule : sram_array_tb

`default_nettype wire

// ==== sram_array.f ====
+incdir+verilog
verilog/sram_pkg.sv
verilog/sram_req_ctrl.sv
verilog/sram_bank.sv
verilog/sram_rsp_queue.sv
verilog/sram_array_top.sv
verif/sram_array_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= sram_array_tb
FILELIST ?= sram_array.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0

.PHONY: sim clean

# build and run, then search the log for the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
